// File: src.f
+incdir+hdl
hdl/trellisPkg.sv
hdl/symbolSequencer.sv
hdl/acsUnit.sv
hdl/comp4TwosComp.sv
hdl/maxMetricEvenOdd.sv
hdl/trellisTracker.sv
dv/trellisTrackerTb.sv

// File: Makefile
TOP = trellisTrackerTb

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  make test   build with Verilator and run $(TOP)"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: dv/trellisTrackerTb.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module trellisTrackerTb;

   localparam int resultTimeout = 12;   // edges allowed past the expected edge
   localparam int drainTimeout  = 100;
   localparam int minSpacing    = 6;    // strobes this far apart are always taken

   logic                   clk;
   logic                   reset;
   logic                   sampleEn;
   trellisPkg::branchVecT  branchMetrics;
   trellisPkg::stateIdxT   index;
   trellisPkg::indexDeltaT indexDelta;
   trellisPkg::metricT     maxVal;
   logic                   resultValid;
   logic                   overrun;

   integer seed;
   int     edgeNum;
   int     errorCount;

   // reference model state
   int modelMetric [`NUM_STATES];
   int modelSymCount;
   int modelPrevIdx;
   int modelIdx;
   int modelDelta;
   int modelMax;
   int modelParity;

   // which strobes the sequencer should take
   bit haveAccepted;
   int lastAcceptEdge;

   // expected results, one entry per accepted symbol
   int expIdxQ[$];
   int expDeltaQ[$];
   int expMaxQ[$];
   int expEdgeQ[$];
   int resultNum;
   int lastMax;

   // wrap-around pair list, each pair holds one even and one odd state
   int boostA [8] = '{19, 19, 19, 17, 3, 19, 9, 1};
   int boostB [8] = '{0, 0, 0, 2, 16, 10, 0, 18};

   trellisTracker dut0 (
      .clk           (clk),
      .reset         (reset),
      .sampleEn      (sampleEn),
      .branchMetrics (branchMetrics),
      .index         (index),
      .indexDelta    (indexDelta),
      .maxVal        (maxVal),
      .resultValid   (resultValid),
      .overrun       (overrun)
   );

   always #5 clk = ~clk;  // 10 ns period

   always @(posedge clk) edgeNum <= edgeNum + 1;

   task automatic abortRun(input string why);
      errorCount++;
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkValue(input string name, input int got, input int exp);
      if (got != exp)
         abortRun($sformatf("FAIL at %0t: %s is %0d, expected %0d", $time, name, got, exp));
   endtask

   function automatic int saturate(input int v);
      if (v > `METRIC_MAX)
         return `METRIC_MAX;
      else if (v < `METRIC_MIN)
         return `METRIC_MIN;
      return v;
   endfunction

   function automatic void modelReset();
      int s;
      for (s = 0; s < `NUM_STATES; s++)
         modelMetric[s] = 0;
      modelSymCount = 0;  // first symbol is even
      modelPrevIdx  = 0;
   endfunction

   // one symbol of the ring trellis, then the max over the current parity
   function automatic void modelStep(input trellisPkg::branchVecT br);
      int oldMetric [`NUM_STATES];
      int s;
      int pred;
      int best;
      int brVal;
      int d;
      oldMetric = modelMetric;
      for (s = 0; s < `NUM_STATES; s++) begin
         pred  = (s + `NUM_STATES - 1) % `NUM_STATES;
         best  = (oldMetric[pred] > oldMetric[s]) ? oldMetric[pred] : oldMetric[s];
         brVal = int'($signed(br[s*`BRANCH_WIDTH +: `BRANCH_WIDTH]));
         modelMetric[s] = saturate(best + brVal);
      end
      modelParity = modelSymCount % 2;
      modelIdx    = modelParity;
      modelMax    = modelMetric[modelParity];
      for (s = modelParity; s < `NUM_STATES; s += 2) begin
         if (modelMetric[s] >= modelMax) begin  // ties go to the higher state
            modelIdx = s;
            modelMax = modelMetric[s];
         end
      end
      d = modelIdx - modelPrevIdx;
      if (d > 9)
         d -= `NUM_STATES;
      else if (d < -10)
         d += `NUM_STATES;
      modelDelta    = d;
      modelPrevIdx  = modelIdx;
      modelSymCount = modelSymCount + 1;
   endfunction

   function automatic trellisPkg::branchVecT fillBranches(input int value);
      trellisPkg::branchVecT br;
      int s;
      br = '0;
      for (s = 0; s < `NUM_STATES; s++)
         br[s*`BRANCH_WIDTH +: `BRANCH_WIDTH] = trellisPkg::branchT'(value);
      return br;
   endfunction

   function automatic trellisPkg::branchVecT randomBranches();
      trellisPkg::branchVecT br;
      int s;
      br = '0;
      for (s = 0; s < `NUM_STATES; s++)
         br[s*`BRANCH_WIDTH +: `BRANCH_WIDTH] = trellisPkg::branchT'($random(seed));
      return br;
   endfunction

   // strongest branch on two states, weakest everywhere else
   function automatic trellisPkg::branchVecT boostBranches(input int a, input int b);
      trellisPkg::branchVecT br;
      br = fillBranches(-128);
      br[a*`BRANCH_WIDTH +: `BRANCH_WIDTH] = trellisPkg::branchT'(127);
      br[b*`BRANCH_WIDTH +: `BRANCH_WIDTH] = trellisPkg::branchT'(127);
      return br;
   endfunction

   // predicts a result for every strobe the sequencer should accept
   always @(negedge clk) begin
      if (reset) begin
         haveAccepted = 1'b0;
         modelReset();
      end else if (sampleEn) begin
         // the strobe is sampled at the coming edge
         if (!haveAccepted || (edgeNum + 1 - lastAcceptEdge) >= minSpacing) begin
            haveAccepted   = 1'b1;
            lastAcceptEdge = edgeNum + 1;
            modelStep(branchMetrics);
            expIdxQ.push_back(modelIdx);
            expDeltaQ.push_back(modelDelta);
            expMaxQ.push_back(modelMax);
            expEdgeQ.push_back(edgeNum + 6);  // five edges after the sampling edge
         end
      end
   end

   // compares each result with the oldest prediction
   always @(negedge clk) begin
      if (!reset) begin
         if (resultValid) begin
            if (expIdxQ.size() == 0) begin
               abortRun("resultValid pulsed with no accepted symbol in flight");
            end else begin
               checkValue("resultValid edge", edgeNum, expEdgeQ[0]);
               checkValue("index", int'(index), expIdxQ[0]);
               checkValue("indexDelta", int'(indexDelta), expDeltaQ[0]);
               checkValue("maxVal", int'(maxVal), expMaxQ[0]);
               // all-zero start, every state ties
               if (resultNum == 0)
                  checkValue("index", int'(index), 18);
               if (resultNum == 1)
                  checkValue("index", int'(index), 19);
               lastMax = int'(maxVal);
               void'(expIdxQ.pop_front());
               void'(expDeltaQ.pop_front());
               void'(expMaxQ.pop_front());
               void'(expEdgeQ.pop_front());
               resultNum++;
            end
         end else if (expEdgeQ.size() != 0 && edgeNum > expEdgeQ[0] + resultTimeout) begin
            abortRun($sformatf("result %0d never arrived after its accepted strobe",
                               resultNum));
         end
      end
   end

   // called on a rising edge, returns on the edge gap cycles later
   task automatic sendSymbol(input trellisPkg::branchVecT br, input int gap);
      sampleEn      <= 1'b1;
      branchMetrics <= br;
      @(posedge clk);
      sampleEn <= 1'b0;
      repeat (gap - 1) @(posedge clk);
   endtask

   task automatic waitForDrain(input string phase);
      int waited;
      waited = 0;
      while (expIdxQ.size() != 0 && waited < drainTimeout) begin
         @(posedge clk);
         waited++;
      end
      if (expIdxQ.size() != 0)
         abortRun($sformatf("results of the %s run never all arrived", phase));
      repeat (2) @(posedge clk);
   endtask

   task automatic checkIdleOutputs();
      @(negedge clk);
      checkValue("index", int'(index), 0);
      checkValue("indexDelta", int'(indexDelta), 0);
      checkValue("maxVal", int'(maxVal), 0);
      checkValue("resultValid", int'(resultValid), 0);
      checkValue("overrun", int'(overrun), 0);
      @(posedge clk);
   endtask

   task automatic applyReset();
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   initial begin
      int i;
      int gap;
      clk            = 1'b0;
      reset          = 1'b1;
      sampleEn       = 1'b0;
      branchMetrics  = '0;
      seed           = 32'hd9e9_062a;
      edgeNum        = 0;
      errorCount     = 0;
      resultNum      = 0;
      lastMax        = 0;
      haveAccepted   = 1'b0;
      lastAcceptEdge = 0;
      modelReset();

      repeat (3) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);
      checkIdleOutputs();

      // zero metrics, even then odd symbol
      sendSymbol(fillBranches(0), minSpacing);
      sendSymbol(fillBranches(0), minSpacing);
      waitForDrain("zero metric");

      // random metrics at random spacing
      for (i = 0; i < 200; i++) begin
         gap = minSpacing + int'($unsigned($random(seed)) % 5);
         sendSymbol(randomBranches(), gap);
      end
      waitForDrain("random metric");

      // upper clamp, then all the way down to the lower clamp
      for (i = 0; i < 20; i++)
         sendSymbol(fillBranches(127), minSpacing);
      waitForDrain("upper saturation");
      checkValue("maxVal clamp", lastMax, `METRIC_MAX);
      for (i = 0; i < 36; i++)
         sendSymbol(fillBranches(-128), minSpacing);
      waitForDrain("lower saturation");
      checkValue("maxVal clamp", lastMax, `METRIC_MIN);

      // all metrics sit on the floor now, so the boosted state wins
      for (i = 0; i < 8; i++)
         sendSymbol(boostBranches(boostA[i], boostB[i]), minSpacing);
      for (i = 7; i >= 0; i--)
         sendSymbol(boostBranches(boostB[i], boostA[i]), minSpacing);
      waitForDrain("wrapped delta");

      // a strobe 3 cycles after an accepted one must be dropped
      @(negedge clk);
      checkValue("overrun", int'(overrun), 0);
      @(posedge clk);
      sendSymbol(randomBranches(), 3);
      sendSymbol(randomBranches(), 3);   // inside the busy window
      sendSymbol(randomBranches(), minSpacing);
      sendSymbol(randomBranches(), minSpacing);
      waitForDrain("overrun");
      @(negedge clk);
      checkValue("overrun", int'(overrun), 1);
      @(posedge clk);
      for (i = 0; i < 5; i++)
         sendSymbol(randomBranches(), minSpacing);
      waitForDrain("post overrun");
      @(negedge clk);
      checkValue("overrun", int'(overrun), 1);  // sticky
      @(posedge clk);

      // reset clears the flag and restarts the trellis
      applyReset();
      checkIdleOutputs();
      sendSymbol(fillBranches(0), minSpacing);
      sendSymbol(fillBranches(0), minSpacing);
      waitForDrain("restart");

      if (errorCount == 0) begin
         $display("** PASS **");
         $finish;
      end else begin
         abortRun("errors were counted during the run");
      end
   end

endmodule

// File: hdl/trellisTracker.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module trellisTracker (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sampleEn,
   input  trellisPkg::branchVecT  branchMetrics,
   output trellisPkg::stateIdxT   index,
   output trellisPkg::indexDeltaT indexDelta,
   output trellisPkg::metricT     maxVal,
   output logic                   resultValid,
   output logic                   overrun
);

   logic                  symEn;
   logic                  even;
   logic                  metricsValid;
   trellisPkg::branchVecT branchReg;
   trellisPkg::metricVecT accMetrics;

   // decode, latches the metrics and paces the symbols
   symbolSequencer uSeq (
      .clk           (clk),
      .reset         (reset),
      .sampleEn      (sampleEn),
      .branchMetrics (branchMetrics),
      .symEn         (symEn),
      .branchReg     (branchReg),
      .even          (even),
      .overrun       (overrun)
   );

   // execute
   acsUnit uAcs (
      .clk          (clk),
      .reset        (reset),
      .symEn        (symEn),
      .branchReg    (branchReg),
      .accMetrics   (accMetrics),
      .metricsValid (metricsValid)
   );

   // result, parity follows the sequencer
   maxMetricEvenOdd uMax (
      .clk         (clk),
      .reset       (reset),
      .symEn       (metricsValid),
      .even        (even),
      .accMetOut   (accMetrics),
      .maxVal      (maxVal),
      .index       (index),
      .indexDelta  (indexDelta),
      .resultValid (resultValid)
   );

   // fixed 5-edge latency holds only if the sequencer spaces the symbols
   latencyFixed: assert property (@(posedge clk) disable iff (reset)
      symEn |-> ##5 resultValid)
      else $error("result did not follow the symbol by the fixed latency");

endmodule

// File: hdl/maxMetricEvenOdd.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module maxMetricEvenOdd (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   symEn,
   input  logic                   even,
   input  trellisPkg::metricVecT  accMetOut,
   output trellisPkg::metricT     maxVal,
   output trellisPkg::stateIdxT   index,
   output trellisPkg::indexDeltaT indexDelta,
   output logic                   resultValid
);

   // below every saturated metric, so padded inputs never win
   localparam trellisPkg::metricT padCode = trellisPkg::metricT'(`METRIC_PAD);

   trellisPkg::metricT    met [`NUM_STATES];
   trellisPkg::metricT    grpVal [2][3];  // stage one winners per parity and group
   trellisPkg::stateIdxT  grpIdx [2][3];  // position within the parity, 0 .. 9
   trellisPkg::metricT    parVal [2];     // stage two winner per parity
   trellisPkg::stateIdxT  parIdx [2];     // winning group, 0 .. 2
   trellisPkg::findStateT state;
   logic                  par;
   trellisPkg::stateIdxT  pos;
   trellisPkg::stateIdxT  newIdx;
   logic signed [5:0]     step;
   logic signed [5:0]     stepWrap;

   genvar s;
   genvar p;
   generate
      for (s = 0; s < `NUM_STATES; s++) begin : gSplit
         assign met[s] = accMetOut[s*`METRIC_WIDTH +: `METRIC_WIDTH];
      end

      // p = 0 searches the even states, p = 1 the odd ones
      for (p = 0; p < 2; p++) begin : gParity
         comp4TwosComp #(.size(`METRIC_WIDTH), .indexOffset(0)) uGrp0 (
            .clk    (clk),
            .reset  (reset),
            .in0    (met[p]),
            .in1    (met[p+2]),
            .in2    (met[p+4]),
            .in3    (met[p+6]),
            .index  (grpIdx[p][0]),
            .maxVal (grpVal[p][0])
         );

         comp4TwosComp #(.size(`METRIC_WIDTH), .indexOffset(4)) uGrp1 (
            .clk    (clk),
            .reset  (reset),
            .in0    (met[p+8]),
            .in1    (met[p+10]),
            .in2    (met[p+12]),
            .in3    (met[p+14]),
            .index  (grpIdx[p][1]),
            .maxVal (grpVal[p][1])
         );

         // only two states left for the last group
         comp4TwosComp #(.size(`METRIC_WIDTH), .indexOffset(8)) uGrp2 (
            .clk    (clk),
            .reset  (reset),
            .in0    (met[p+16]),
            .in1    (met[p+18]),
            .in2    (padCode),
            .in3    (padCode),
            .index  (grpIdx[p][2]),
            .maxVal (grpVal[p][2])
         );

         // stage two picks the group
         comp4TwosComp #(.size(`METRIC_WIDTH), .indexOffset(0)) uPar (
            .clk    (clk),
            .reset  (reset),
            .in0    (grpVal[p][0]),
            .in1    (grpVal[p][1]),
            .in2    (grpVal[p][2]),
            .in3    (padCode),
            .index  (parIdx[p]),
            .maxVal (parVal[p])
         );
      end
   endgenerate

   assign par = ~even;  // low bit of the state index

   always_comb begin
      case (parIdx[par][1:0])
         2'd0:    pos = grpIdx[par][0];
         2'd1:    pos = grpIdx[par][1];
         default: pos = grpIdx[par][2];
      endcase
   end

   assign newIdx = {pos[3:0], par};
   assign step   = $signed({1'b0, newIdx}) - $signed({1'b0, index});

   // shortest way round the ring
   always_comb begin
      if (step > 6'sd9)
         stepWrap = step - 6'sd20;
      else if (step < -6'sd10)
         stepWrap = step + 6'sd20;
      else
         stepWrap = step;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= trellisPkg::IDLE;
         index       <= '0;
         indexDelta  <= '0;
         maxVal      <= '0;
         resultValid <= 1'b0;
      end else begin
         resultValid <= 1'b0;
         case (state)
            trellisPkg::IDLE: begin
               if (symEn)
                  state <= trellisPkg::STAGE1;
            end
            trellisPkg::STAGE1: state <= trellisPkg::STAGE2;  // stage one registered
            trellisPkg::STAGE2: state <= trellisPkg::STAGE3;  // stage two registered
            trellisPkg::STAGE3: begin
               index       <= newIdx;
               indexDelta  <= trellisPkg::indexDeltaT'(stepWrap);
               maxVal      <= parVal[par];
               resultValid <= 1'b1;
               state       <= trellisPkg::IDLE;
            end
            default: state <= trellisPkg::IDLE;
         endcase
      end
   end

   indexRange: assert property (@(posedge clk) disable iff (reset)
      index < `NUM_STATES)
      else $error("index %0d is outside the trellis", index);

endmodule

// File: hdl/comp4TwosComp.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module comp4TwosComp #(
   parameter int size        = 12,
   parameter int indexOffset = 0
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic signed [size-1:0] in0,
   input  logic signed [size-1:0] in1,
   input  logic signed [size-1:0] in2,
   input  logic signed [size-1:0] in3,
   output trellisPkg::stateIdxT   index,
   output logic signed [size-1:0] maxVal
);

   logic signed [size-1:0] maxLo;
   logic signed [size-1:0] maxHi;
   logic signed [size-1:0] maxAll;
   logic                   selLo;
   logic                   selHi;
   logic                   selAll;
   logic [1:0]             pos;

   // ties always go to the higher-numbered input
   assign selLo  = (in1 >= in0);
   assign selHi  = (in3 >= in2);
   assign maxLo  = selLo ? in1 : in0;
   assign maxHi  = selHi ? in3 : in2;
   assign selAll = (maxHi >= maxLo);
   assign maxAll = selAll ? maxHi : maxLo;

   assign pos = selAll ? {1'b1, selHi} : {1'b0, selLo};

   always_ff @(posedge clk) begin
      if (reset) begin
         index  <= '0;
         maxVal <= '0;
      end else begin
         index  <= trellisPkg::stateIdxT'(pos) + trellisPkg::stateIdxT'(indexOffset);
         maxVal <= maxAll;
      end
   end

endmodule

// File: hdl/acsUnit.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module acsUnit (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  symEn,
   input  trellisPkg::branchVecT branchReg,
   output trellisPkg::metricVecT accMetrics,
   output logic                  metricsValid
);

   wire trellisPkg::metricVecT accNext;

   genvar s;
   generate
      for (s = 0; s < `NUM_STATES; s++) begin : gState
         // ring trellis, state s is entered from itself and from s-1
         localparam int pred = (s + `NUM_STATES - 1) % `NUM_STATES;

         trellisPkg::metricT            own;
         trellisPkg::metricT            prev;
         trellisPkg::metricT            best;
         trellisPkg::metricT            sat;
         trellisPkg::branchT            br;
         logic signed [`METRIC_WIDTH:0] sum;  // one guard bit

         assign own  = accMetrics[s*`METRIC_WIDTH +: `METRIC_WIDTH];
         assign prev = accMetrics[pred*`METRIC_WIDTH +: `METRIC_WIDTH];
         assign br   = branchReg[s*`BRANCH_WIDTH +: `BRANCH_WIDTH];

         assign best = (prev > own) ? prev : own;  // compare-select
         assign sum  = (`METRIC_WIDTH+1)'(best) + (`METRIC_WIDTH+1)'(br);  // sign extended

         always_comb begin
            if (sum > (`METRIC_WIDTH+1)'(`METRIC_MAX))
               sat = trellisPkg::metricT'(`METRIC_MAX);
            else if (sum < (`METRIC_WIDTH+1)'(`METRIC_MIN))
               sat = trellisPkg::metricT'(`METRIC_MIN);
            else
               sat = sum[`METRIC_WIDTH-1:0];
         end

         assign accNext[s*`METRIC_WIDTH +: `METRIC_WIDTH] = sat;

         // the padding code must stay out of the live metrics
         noPadCode: assert property (@(posedge clk) disable iff (reset)
            metricsValid |-> (own != trellisPkg::metricT'(`METRIC_PAD)))
            else $error("state %0d holds the reserved padding code", s);
      end
   endgenerate

   always_ff @(posedge clk) begin
      if (reset) begin
         accMetrics   <= '0;
         metricsValid <= 1'b0;
      end else begin
         metricsValid <= symEn;
         if (symEn)
            accMetrics <= accNext;
      end
   end

endmodule

// File: hdl/symbolSequencer.sv
`timescale 1ns/1ps
`include "trellis_consts.svh"

module symbolSequencer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  sampleEn,
   input  trellisPkg::branchVecT branchMetrics,
   output logic                  symEn,
   output trellisPkg::branchVecT branchReg,
   output logic                  even,
   output logic                  overrun
);

   // cycles from an accepted strobe until the max finder is free again
   localparam int busyCycles = 5;

   logic [2:0] busyCnt;
   logic       busy;
   logic       accept;

   assign busy   = (busyCnt != 3'd0);
   assign accept = sampleEn && !busy;  // strobes inside the window are dropped

   always_ff @(posedge clk) begin
      if (reset) begin
         symEn   <= 1'b0;
         even    <= 1'b0;  // flips to even on the first accepted strobe
         overrun <= 1'b0;
         busyCnt <= 3'd0;
      end else begin
         symEn <= accept;
         if (accept) begin
            even    <= ~even;
            busyCnt <= 3'(busyCycles);
         end else if (busy) begin
            busyCnt <= busyCnt - 3'd1;
         end
         if (sampleEn && busy)
            overrun <= 1'b1;  // sticky until reset
      end
   end

   // branch metrics held for the whole symbol
   always_ff @(posedge clk) begin
      if (accept)
         branchReg <= branchMetrics;
   end

   // the busy window must keep accepted symbols apart
   symEnSpacing: assert property (@(posedge clk) disable iff (reset)
      symEn |=> !symEn)
      else $error("symEn asserted on two consecutive cycles");

endmodule

// File: hdl/trellisPkg.sv
`include "trellis_consts.svh"

package trellisPkg;

   // one signed accumulated metric
   typedef logic signed [`METRIC_WIDTH-1:0] metricT;

   // one signed branch metric
   typedef logic signed [`BRANCH_WIDTH-1:0] branchT;

   // all states packed, state 0 in the lowest word
   typedef logic [`NUM_STATES*`METRIC_WIDTH-1:0] metricVecT;
   typedef logic [`NUM_STATES*`BRANCH_WIDTH-1:0] branchVecT;

   typedef logic [4:0] stateIdxT;           // 0 .. 19
   typedef logic signed [4:0] indexDeltaT;  // -10 .. +9

   // max finder sequencing, gray coded
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      STAGE1 = 2'b01,
      STAGE2 = 2'b11,
      STAGE3 = 2'b10
   } findStateT;

endpackage

// File: hdl/trellis_consts.svh
`ifndef TRELLIS_CONSTS_SVH
`define TRELLIS_CONSTS_SVH

// accumulated and branch metric word widths
`define METRIC_WIDTH 12
`define BRANCH_WIDTH 8

// states in the phase trellis, fixed by the comparator tree wiring
`define NUM_STATES 20

// symmetric saturation limits for the accumulated metrics
`define METRIC_MAX ((1 << (`METRIC_WIDTH - 1)) - 1)
`define METRIC_MIN (-`METRIC_MAX)

// most negative code, never produced by the ACS
// the comparators use it as padding so a real metric always wins against it
`define METRIC_PAD (-`METRIC_MAX - 1)

`endif
